//--- common/execPkg.sv
`default_nettype none

package execPkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    typedef logic [31:0] wordT;   // Register operand and result
    typedef logic [23:0] immT;    // Immediate from the decoder
    typedef logic [7:0]  statusT; // C | N | x | x | x | x | CmpHi | CmpLo

    localparam int unsigned carryBit = 7;
    localparam int unsigned negBit   = 6; // Also picks signed compare
    localparam int unsigned cmpHiBit = 1;
    localparam int unsigned cmpLoBit = 0;

    // Logic/shift unit sub-op codes
    localparam logic [2:0] lsAnd  = 3'd0;
    localparam logic [2:0] lsNand = 3'd1;
    localparam logic [2:0] lsOr   = 3'd2;
    localparam logic [2:0] lsNor  = 3'd3;
    localparam logic [2:0] lsXor  = 3'd4;
    localparam logic [2:0] lsXnor = 3'd5;
    localparam logic [2:0] lsShl  = 3'd6;
    localparam logic [2:0] lsShr  = 3'd7;

    //////////////////////////////
    // Enums
    //////////////////////////////

    typedef enum logic [7:0] {
        opWait    = 8'd0,
        opAddIm   = 8'd1,
        opAddImC  = 8'd2,
        opAdd     = 8'd3,
        opAddC    = 8'd4,
        opSubIm   = 8'd5,
        opSubImC  = 8'd6,
        opSub     = 8'd7,
        opSubC    = 8'd8,
        opShl     = 8'd13,
        opShlC    = 8'd14,
        opShr     = 8'd15,
        opShrC    = 8'd16,
        opAnd     = 8'd17,
        opNand    = 8'd18,
        opOr      = 8'd19,
        opNor     = 8'd20,
        opXor     = 8'd21,
        opXnor    = 8'd22,
        opRjp     = 8'd23,
        opJp      = 8'd24,
        opJeq     = 8'd26,
        opJg      = 8'd27,
        opJl      = 8'd28,
        opJgeq    = 8'd29,
        opJleq    = 8'd30,
        opCp      = 8'd31,
        opCpi     = 8'd33,
        opLdi     = 8'd37,
        opMov     = 8'd38,
        opSld     = 8'd46,
        opEndWait = 8'd254,
        opNop     = 8'd255
    } opcodeT;

    typedef enum logic [2:0] {
        pcHold   = 3'd0,
        pcInc    = 3'd1,
        pcSet    = 3'd3,
        pcAddRel = 3'd4
    } pcCmdT;

    typedef enum logic [1:0] {
        srcArith      = 2'd0,
        srcLogicShift = 2'd1,
        srcMove       = 2'd2
    } resultSrcT;

    //////////////////////////////
    // Request and response
    //////////////////////////////

    typedef struct packed {
        opcodeT opcode;
        wordT   operandA;
        wordT   operandB;
        immT    immediate;
        statusT statusIn;
    } execReqT;

    typedef struct packed {
        logic   regWrite;
        wordT   result;
        logic   statusWrite;
        statusT statusOut;
        pcCmdT  pcCmd;
        wordT   pcTarget;
    } execRespT;

endpackage

`default_nettype wire

//--- dv/execChecker.sv
`timescale 1ns/1ps
`default_nettype none

module execChecker
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    expValid,
    input  wire execPkg::execRespT expected,
    input  wire                    respValid,
    input  wire execPkg::execRespT resp,
    output int                     pending,
    output int                     errCount
);
    import execPkg::*;

    execRespT expQ[$];
    int       stampQ[$]; // Cycle of each strobe
    int       cycle;
    execRespT want;
    int       stamp;

    initial
    begin
        pending  = 0;
        errCount = 0;
        cycle    = 0;
    end

    function automatic void compareField(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endfunction

    //////////////////////////////
    // Response matching
    //////////////////////////////

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            expQ.delete();
            stampQ.delete();
            cycle   = 0;
            pending = 0;
        end
        else
        begin
            cycle++;
            if (respValid)
            begin
                if (expQ.size() == 0)
                begin
                    $display("A response came at time %0t with no operation pending", $time);
                    errCount++;
                end
                else
                begin
                    want  = expQ.pop_front();
                    stamp = stampQ.pop_front();
                    if (cycle - stamp != 2)
                    begin
                        $display("The response at time %0t came %0d edges after its strobe",
                                 $time, cycle - stamp);
                        errCount++;
                    end
                    compareField("regWrite", resp.regWrite, want.regWrite);
                    compareField("result", resp.result, want.result);
                    compareField("statusWrite", resp.statusWrite, want.statusWrite);
                    compareField("statusOut", resp.statusOut, want.statusOut);
                    compareField("pcCmd", resp.pcCmd, want.pcCmd);
                    compareField("pcTarget", resp.pcTarget, want.pcTarget);
                end
            end
            if (expValid) // Strobe seen by the DUT at this edge
            begin
                expQ.push_back(expected);
                stampQ.push_back(cycle);
            end
            pending = expQ.size();
        end
    end

endmodule

`default_nettype wire

//--- dv/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitTb;
    import execPkg::*;

    localparam int drainLimit = 50; // Cycles allowed for the last responses

    logic     clk;
    logic     rst;
    logic     opValid;
    execReqT  req;
    logic     respValid;
    execRespT resp;
    logic     expValid;
    execRespT expected;
    int       pending;
    int       checkErrors;
    int       otherErrors;
    int       opCount;

    execUnit i_execUnit
    (
        .clk       (clk),
        .rst       (rst),
        .opValid   (opValid),
        .req       (req),
        .respValid (respValid),
        .resp      (resp)
    );

    execChecker uChecker
    (
        .clk       (clk),
        .rst       (rst),
        .expValid  (expValid),
        .expected  (expected),
        .respValid (respValid),
        .resp      (resp),
        .pending   (pending),
        .errCount  (checkErrors)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus from the test file
    //////////////////////////////

    task automatic runTests();
        int         fd;
        int         fields;
        int         idle;
        string      line;
        logic [7:0] op;
        wordT       a;
        wordT       b;
        immT        im;
        statusT     st;
        logic       rw;
        wordT       res;
        logic       sw;
        statusT     stOut;
        logic [2:0] pc;
        wordT       tgt;
        fd = $fopen("dv/execUnit_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open dv/execUnit_tests.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line[0] == "/") // Blank or comment line
                continue;
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                             op, a, b, im, st, rw, res, sw, stOut, pc, tgt);
            if (fields != 11)
            begin
                $display("Skipping a malformed line in the test file: %s", line);
                otherErrors++;
                continue;
            end
            @(posedge clk);
            opValid  <= 1'b1;
            req      <= '{opcodeT'(op), a, b, im, st};
            expValid <= 1'b1;
            expected <= '{rw, res, sw, stOut, pcCmdT'(pc), tgt};
            opCount++;
            idle = $urandom_range(2, 0); // Zero gives back-to-back strobes
            repeat (idle)
            begin
                @(posedge clk);
                opValid  <= 1'b0;
                expValid <= 1'b0;
            end
        end
        $fclose(fd);
        @(posedge clk);
        opValid  <= 1'b0;
        expValid <= 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        int waited;
        int assertErrors;
        void'($urandom(32'h3016f7bc));
        rst         = 1'b0;
        opValid     = 1'b0;
        req         = '0;
        expValid    = 1'b0;
        expected    = '0;
        otherErrors = 0;
        opCount     = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        runTests();
        waited = 0;
        repeat (3) @(negedge clk);
        while (pending != 0 && waited < drainLimit)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0)
        begin
            $display("Timed out with %0d responses still missing", pending);
            otherErrors++;
        end
        repeat (4) @(negedge clk); // Room for stray responses
        assertErrors = i_execUnit.uAssert.failCount;
        $display("Operations %0d, check errors %0d, assertion errors %0d, other errors %0d",
                 opCount, checkErrors, assertErrors, otherErrors);
        if (checkErrors + assertErrors + otherErrors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/execUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitAssert
(
    input wire                    clk,
    input wire                    rst,
    input wire                    opValid,
    input wire                    respValid,
    input wire execPkg::execRespT resp
);
    import execPkg::*;

    int failCount = 0;

    strobeGated: assert property (@(posedge clk) disable iff (!rst)
        !respValid |-> !resp.regWrite && !resp.statusWrite)
        else
        begin
            failCount++;
            $error("Write strobe high while respValid is low");
        end

    pcIdle: assert property (@(posedge clk) disable iff (!rst)
        !respValid |-> resp.pcCmd == pcHold)
        else
        begin
            failCount++;
            $error("pcCmd is not pcHold while respValid is low");
        end

    // Two edges from strobe to response
    respLatency: assert property (@(posedge clk) disable iff (!rst)
        respValid |-> $past(opValid, 2))
        else
        begin
            failCount++;
            $error("respValid without an opValid two edges earlier");
        end

    resetIdle: assert property (@(posedge clk)
        !rst |-> !respValid && resp == '0)
        else
        begin
            failCount++;
            $error("Outputs not idle during reset");
        end

endmodule

bind execUnit execUnitAssert uAssert
(
    .clk       (clk),
    .rst       (rst),
    .opValid   (opValid),
    .respValid (respValid),
    .resp      (resp)
);

`default_nettype wire

//--- dv/execUnit_tests.txt
// op A B imm status | regWrite result statusWrite statusOut pcCmd pcTarget (all hex)
// pcCmd: 0 hold, 1 inc, 3 set, 4 relative add
03 00000005 00000003 000000 24 1 00000008 1 24 1 00000000
03 ffffffff 00000002 000000 00 1 00000001 1 80 1 00000000
03 7fffffff 00000001 000000 c3 1 80000000 1 43 1 00000000
04 00000010 00000020 000000 80 1 00000031 1 00 1 00000000
04 fffffffe 00000001 000000 81 1 00000000 1 81 1 00000000
01 00001000 deadbeef 000123 3c 1 00001123 1 3c 1 00000000
02 ffffff00 00000000 0000ff 80 1 00000000 1 80 1 00000000
07 00000009 00000004 000000 00 1 00000005 1 00 1 00000000
07 00000003 00000005 000000 00 1 fffffffe 1 c0 1 00000000
08 00000010 00000004 000000 80 1 0000000d 1 00 1 00000000
08 00000000 00000001 000000 3c 1 ffffffff 1 fc 1 00000000
05 00000100 00000000 000001 02 1 000000ff 1 02 1 00000000
06 00000005 00000000 000010 80 1 fffffff6 1 c0 1 00000000
11 f0f0ff00 ff00f0f0 000000 5a 1 f000f000 0 5a 1 00000000
12 f0f0ff00 ff00f0f0 000000 5a 1 0fff0fff 0 5a 1 00000000
13 f0f0ff00 ff00f0f0 000000 5a 1 fff0fff0 0 5a 1 00000000
14 f0f0ff00 ff00f0f0 000000 5a 1 000f000f 0 5a 1 00000000
15 f0f0ff00 ff00f0f0 000000 5a 1 0ff00ff0 0 5a 1 00000000
16 f0f0ff00 ff00f0f0 000000 5a 1 f00ff00f 0 5a 1 00000000
0d 80000001 00000000 000000 80 1 80000001 0 80 1 00000000
0d 80000001 00000000 000021 80 1 00000002 0 80 1 00000000
0d 00000003 00000000 00001f 00 1 80000000 0 00 1 00000000
0f 80000001 00000000 000000 80 1 80000001 0 80 1 00000000
0f 80000001 00000000 000001 80 1 40000000 0 80 1 00000000
0f c0000000 00000000 00001f 00 1 00000001 0 00 1 00000000
0e 80000000 00000000 000001 00 1 00000000 1 80 1 00000000
0e 40000000 00000000 000001 80 1 80000001 1 00 1 00000000
0e 12345678 00000000 000000 80 1 12345678 1 80 1 00000000
10 00000001 00000000 000001 00 1 00000000 1 80 1 00000000
10 00000002 00000000 000001 81 1 80000001 1 01 1 00000000
10 40000000 00000000 00001f 00 1 00000000 1 80 1 00000000
1f ffffffff 00000001 000000 00 0 00000000 1 02 1 00000000
1f ffffffff 00000001 000000 40 0 00000000 1 41 1 00000000
1f 12345678 12345678 000000 bc 0 00000000 1 bf 1 00000000
1f 00000001 80000000 000000 83 0 00000000 1 81 1 00000000
1f 00000001 80000000 000000 c0 0 00000000 1 c2 1 00000000
21 ffffffff 00000000 000010 40 0 00000000 1 41 1 00000000
21 ffffffff 00000000 000010 00 0 00000000 1 02 1 00000000
21 000000aa 00000000 0000aa 43 0 00000000 1 43 1 00000000
18 00000000 00000000 001234 00 0 00000000 0 00 3 00001234
17 00000000 00000000 000010 00 0 00000000 0 00 4 00000011
17 00000000 00000000 ffffff 00 0 00000000 0 00 4 01000000
1a 00000000 00000000 000100 03 0 00000000 0 03 3 00000100
1a 00000000 00000000 000100 02 0 00000000 0 02 1 00000000
1a 00000000 00000000 000100 01 0 00000000 0 01 1 00000000
1b 00000000 00000000 000100 03 0 00000000 0 03 1 00000000
1b 00000000 00000000 000100 02 0 00000000 0 02 3 00000100
1b 00000000 00000000 000100 01 0 00000000 0 01 1 00000000
1c 00000000 00000000 000100 03 0 00000000 0 03 1 00000000
1c 00000000 00000000 000100 02 0 00000000 0 02 1 00000000
1c 00000000 00000000 000100 01 0 00000000 0 01 3 00000100
1d 00000000 00000000 000100 03 0 00000000 0 03 3 00000100
1d 00000000 00000000 000100 02 0 00000000 0 02 3 00000100
1d 00000000 00000000 000100 01 0 00000000 0 01 1 00000000
1e 00000000 00000000 000100 03 0 00000000 0 03 3 00000100
1e 00000000 00000000 000100 02 0 00000000 0 02 1 00000000
1e 00000000 00000000 000100 01 0 00000000 0 01 3 00000100
00 00000011 00000022 000033 c3 0 00000000 0 c3 0 00000000
09 00000011 00000022 000033 00 0 00000000 0 00 0 00000000
25 11111111 22222222 abcdef 00 1 00abcdef 0 00 1 00000000
26 11111111 cafef00d 000000 00 1 cafef00d 0 00 1 00000000
2e 11111111 22222222 000000 a5 1 000000a5 0 a5 1 00000000
fe 11111111 22222222 000044 3c 0 00000000 0 3c 1 00000000
ff 11111111 22222222 000044 00 0 00000000 0 00 1 00000000

//--- execUnit.f
common/execPkg.sv
rtl/arithUnit.sv
rtl/logicShiftUnit.sv
rtl/compareUnit.sv
rtl/execControl.sv
rtl/execUnit.sv
dv/execUnit_assert.sv
dv/execChecker.sv
dv/execUnitTb.sv

//--- rtl/arithUnit.sv
`timescale 1ns/1ps
`default_nettype none

module arithUnit
(
    input  wire execPkg::wordT opA,
    input  wire execPkg::wordT opB,
    input  wire execPkg::immT  imm,
    input  wire                useImm,
    input  wire                carryIn,
    input  wire [1:0]          arithOp,    // [1] with carry, [0] subtract
    output execPkg::wordT      arithSum,
    output logic               arithCarry
);
    import execPkg::*;

    wordT        operand;
    logic        cin;
    logic [32:0] full;

    assign operand = useImm ? {8'd0, imm} : opB;
    assign cin     = arithOp[1] & carryIn;

    // Subtract with carry adds the carry back as A - op + C
    always_comb
    begin
        if (arithOp[0])
            full = {1'b0, opA} - {1'b0, operand} + {32'd0, cin};
        else
            full = {1'b0, opA} + {1'b0, operand} + {32'd0, cin};
    end

    assign arithSum   = full[31:0];
    assign arithCarry = full[32]; // Borrow on subtract

endmodule

`default_nettype wire

//--- rtl/compareUnit.sv
`timescale 1ns/1ps
`default_nettype none

module compareUnit
(
    input  wire execPkg::wordT opA,
    input  wire execPkg::wordT opB,
    input  wire execPkg::immT  imm,
    input  wire                useImm,
    input  wire                signedMode,
    output logic [1:0]         cmpFlags    // {hi, lo}
);
    import execPkg::*;

    wordT operand;
    logic isEq;
    logic isGt;

    assign operand = useImm ? {8'd0, imm} : opB;
    assign isEq    = (opA == operand);
    assign isGt    = signedMode ? ($signed(opA) > $signed(operand)) : (opA > operand);

    // 11 equal, 10 greater, 01 less
    assign cmpFlags = {isEq | isGt, isEq | ~isGt};

endmodule

`default_nettype wire

//--- rtl/execControl.sv
`timescale 1ns/1ps
`default_nettype none

module execControl
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   opValid,
    input  wire execPkg::execReqT req,
    output logic                  respValid,
    output execPkg::execRespT     resp,
    output execPkg::wordT         opA,
    output execPkg::wordT         opB,
    output execPkg::immT          imm,
    output logic                  carryIn,
    output logic                  signedMode,
    output logic                  useImm,
    output logic [1:0]            arithOp,
    output logic [2:0]            shiftOp,
    input  wire execPkg::wordT    arithSum,
    input  wire                   arithCarry,
    input  wire execPkg::wordT    lsValue,
    input  wire                   lsCarry,
    input  wire [1:0]             cmpFlags
);
    import execPkg::*;

    execReqT   reqReg;
    logic      reqValid;
    opcodeT    opcode;
    wordT      immExt;
    logic      subOp;
    logic      carryOp;
    logic      jumpTaken;
    logic      regWr;
    logic      statusWr;
    logic      updArith;
    logic      updShiftCarry;
    logic      updCmp;
    resultSrcT resultSrc;
    pcCmdT     pcNext;
    wordT      moveValue;
    wordT      selValue;
    statusT    statusNext;
    execRespT  respNext;

    //////////////////////////////
    // Request stage
    //////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            reqValid <= 1'b0;
        else
            reqValid <= opValid;
    end

    always_ff @(posedge clk)
    begin
        if (opValid)
            reqReg <= req;
    end

    assign opcode     = reqReg.opcode;
    assign immExt     = {8'd0, reqReg.immediate}; // Immediate is never signed
    assign opA        = reqReg.operandA;
    assign opB        = reqReg.operandB;
    assign imm        = reqReg.immediate;
    assign signedMode = reqReg.statusIn[negBit];

    assign useImm  = opcode inside {opAddIm, opAddImC, opSubIm, opSubImC, opCpi};
    assign subOp   = opcode inside {opSubIm, opSubImC, opSub, opSubC};
    assign carryOp = opcode inside {opAddImC, opAddC, opSubImC, opSubC, opShlC, opShrC};
    assign carryIn = reqReg.statusIn[carryBit] & carryOp; // Plain shifts shift in zero
    assign arithOp = {carryOp, subOp};

    // Conditions from the compare flags of the incoming status
    always_comb
    begin
        case (opcode)
            opJeq:   jumpTaken = reqReg.statusIn[cmpHiBit] & reqReg.statusIn[cmpLoBit];
            opJg:    jumpTaken = reqReg.statusIn[cmpHiBit] & ~reqReg.statusIn[cmpLoBit];
            opJl:    jumpTaken = ~reqReg.statusIn[cmpHiBit] & reqReg.statusIn[cmpLoBit];
            opJgeq:  jumpTaken = reqReg.statusIn[cmpHiBit];
            opJleq:  jumpTaken = reqReg.statusIn[cmpLoBit];
            default: jumpTaken = 1'b0;
        endcase
    end

    //////////////////////////////
    // Decode
    //////////////////////////////

    always_comb
    begin
        shiftOp       = lsAnd;
        resultSrc     = srcArith;
        regWr         = 1'b0;
        statusWr      = 1'b0;
        updArith      = 1'b0;
        updShiftCarry = 1'b0;
        updCmp        = 1'b0;
        pcNext        = pcInc;
        moveValue     = immExt;
        case (opcode)
            opAddIm, opAddImC, opAdd, opAddC, opSubIm, opSubImC, opSub, opSubC:
            begin
                regWr    = 1'b1;
                statusWr = 1'b1;
                updArith = 1'b1; // Carry and negative
            end
            opAnd, opNand, opOr, opNor, opXor, opXnor, opShl, opShr:
            begin
                regWr     = 1'b1;
                resultSrc = srcLogicShift;
                case (opcode)
                    opAnd:   shiftOp = lsAnd;
                    opNand:  shiftOp = lsNand;
                    opOr:    shiftOp = lsOr;
                    opNor:   shiftOp = lsNor;
                    opXor:   shiftOp = lsXor;
                    opXnor:  shiftOp = lsXnor;
                    opShl:   shiftOp = lsShl;
                    default: shiftOp = lsShr;
                endcase
            end
            opShlC, opShrC:
            begin
                regWr         = 1'b1;
                statusWr      = 1'b1;
                updShiftCarry = 1'b1;
                resultSrc     = srcLogicShift;
                shiftOp       = (opcode == opShlC) ? lsShl : lsShr;
            end
            opCp, opCpi:
            begin
                statusWr = 1'b1;
                updCmp   = 1'b1;
            end
            opJp:                           pcNext = pcSet;
            opRjp:                          pcNext = pcAddRel;
            opJeq, opJg, opJl, opJgeq, opJleq: pcNext = jumpTaken ? pcSet : pcInc;
            opLdi, opMov, opSld:
            begin
                regWr     = 1'b1;
                resultSrc = srcMove;
                if (opcode == opMov)
                    moveValue = reqReg.operandB;
                else if (opcode == opSld)
                    moveValue = {24'd0, reqReg.statusIn};
            end
            opNop, opEndWait:               pcNext = pcInc;
            default:                        pcNext = pcHold; // WAIT and unknown codes
        endcase
    end

    //////////////////////////////
    // Result and status
    //////////////////////////////

    always_comb
    begin
        case (resultSrc)
            srcArith:      selValue = arithSum;
            srcLogicShift: selValue = lsValue;
            default:       selValue = moveValue;
        endcase
    end

    always_comb
    begin
        statusNext = reqReg.statusIn; // Unused bits pass through
        if (updArith)
        begin
            statusNext[carryBit] = arithCarry;
            statusNext[negBit]   = arithSum[31];
        end
        if (updShiftCarry)
            statusNext[carryBit] = lsCarry;
        if (updCmp)
        begin
            statusNext[cmpHiBit] = cmpFlags[1];
            statusNext[cmpLoBit] = cmpFlags[0];
        end
    end

    always_comb
    begin
        respNext.regWrite    = regWr;
        respNext.result      = regWr ? selValue : '0;
        respNext.statusWrite = statusWr;
        respNext.statusOut   = statusNext;
        respNext.pcCmd       = pcNext;
        case (pcNext)
            pcSet:    respNext.pcTarget = immExt;
            pcAddRel: respNext.pcTarget = immExt + 32'd1;
            default:  respNext.pcTarget = '0;
        endcase
    end

    // Response stage clears its fields when nothing is in flight
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            respValid <= 1'b0;
            resp      <= '0;
        end
        else
        begin
            respValid <= reqValid;
            resp      <= reqValid ? respNext : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit
(
    input  wire                clk,
    input  wire                rst,
    input  wire                opValid,
    input  wire execPkg::execReqT  req,
    output logic               respValid,
    output execPkg::execRespT  resp
);
    import execPkg::*;

    wordT       opA;
    wordT       opB;
    immT        imm;
    logic       carryIn;
    logic       signedMode;
    logic       useImm;
    logic [1:0] arithOp;
    logic [2:0] shiftOp;
    wordT       arithSum;
    logic       arithCarry;
    wordT       lsValue;
    logic       lsCarry;
    logic [1:0] cmpFlags;

    execControl uControl
    (
        .clk        (clk),
        .rst        (rst),
        .opValid    (opValid),
        .req        (req),
        .respValid  (respValid),
        .resp       (resp),
        .opA        (opA),
        .opB        (opB),
        .imm        (imm),
        .carryIn    (carryIn),
        .signedMode (signedMode),
        .useImm     (useImm),
        .arithOp    (arithOp),
        .shiftOp    (shiftOp),
        .arithSum   (arithSum),
        .arithCarry (arithCarry),
        .lsValue    (lsValue),
        .lsCarry    (lsCarry),
        .cmpFlags   (cmpFlags)
    );

    arithUnit uArith
    (
        .opA        (opA),
        .opB        (opB),
        .imm        (imm),
        .useImm     (useImm),
        .carryIn    (carryIn),
        .arithOp    (arithOp),
        .arithSum   (arithSum),
        .arithCarry (arithCarry)
    );

    logicShiftUnit uLogicShift
    (
        .opA     (opA),
        .opB     (opB),
        .imm     (imm),
        .carryIn (carryIn),
        .shiftOp (shiftOp),
        .lsValue (lsValue),
        .lsCarry (lsCarry)
    );

    compareUnit uCompare
    (
        .opA        (opA),
        .opB        (opB),
        .imm        (imm),
        .useImm     (useImm),
        .signedMode (signedMode),
        .cmpFlags   (cmpFlags)
    );

endmodule

`default_nettype wire

//--- rtl/logicShiftUnit.sv
`timescale 1ns/1ps
`default_nettype none

module logicShiftUnit
(
    input  wire execPkg::wordT opA,
    input  wire execPkg::wordT opB,
    input  wire execPkg::immT  imm,
    input  wire                carryIn,
    input  wire [2:0]          shiftOp,
    output execPkg::wordT      lsValue,
    output logic               lsCarry
);
    import execPkg::*;

    logic [4:0]  shamt;
    logic [33:0] leftExt;
    logic [33:0] rightExt;

    assign shamt = imm[4:0];

    // Guard bit on each side catches the last bit shifted out
    assign leftExt  = {1'b0, opA, carryIn} << shamt;
    assign rightExt = {carryIn, opA, 1'b0} >> shamt;

    always_comb
    begin
        lsCarry = carryIn; // Kept when nothing shifts out
        case (shiftOp)
            lsAnd:  lsValue = opA & opB;
            lsNand: lsValue = ~(opA & opB);
            lsOr:   lsValue = opA | opB;
            lsNor:  lsValue = ~(opA | opB);
            lsXor:  lsValue = opA ^ opB;
            lsXnor: lsValue = ~(opA ^ opB);
            lsShl:
            begin
                lsValue = leftExt[32:1];
                if (shamt != 5'd0)
                    lsCarry = leftExt[33];
            end
            default:
            begin
                lsValue = rightExt[32:1];
                if (shamt != 5'd0)
                    lsCarry = rightExt[0];
            end
        endcase
    end

endmodule

`default_nettype wire
